//--- hdl/dram_pkg.sv
// dram model package with widths, address fields, request type and bank states
`default_nettype none

package dram_pkg;

    localparam int bus_width    = 16;
    localparam int burst_len    = 4;
    localparam int line_width   = bus_width * burst_len;
    localparam int ba_width     = 2;
    localparam int ra_width     = 3;
    localparam int ca_width     = 2;
    localparam int offset_width = 3;   // byte offset inside one line
    localparam int addr_width   = offset_width + ca_width + ba_width + ra_width;
    localparam int num_banks    = 2 ** ba_width;

    typedef logic [line_width-1:0] line_t;
    typedef logic [bus_width-1:0]  beat_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [ra_width-1:0]   row_t;

    typedef struct packed {
        logic  read;
        addr_t addr;
        line_t wdata;
    } dram_req_t;

    typedef enum logic [1:0] {
        bank_idle,
        bank_pre,
        bank_act,
        bank_col
    } bank_state_e;

    // address layout from the low end is offset, column, bank, row
    function automatic logic [ca_width-1:0] get_col(addr_t a);
        return a[offset_width +: ca_width];
    endfunction

    function automatic logic [ba_width-1:0] get_bank(addr_t a);
        return a[offset_width + ca_width +: ba_width];
    endfunction

    function automatic row_t get_row(addr_t a);
        return a[offset_width + ca_width + ba_width +: ra_width];
    endfunction

endpackage

`default_nettype wire

//--- hdl/bank_if.sv
// bank interface carrying request issue, bank status and read completion
`timescale 1ns/1ps
`default_nettype none

interface bank_if;
    import dram_pkg::*;

    logic      issue;      // pulses for one cycle to hand req to the bank
    dram_req_t req;

    logic      idle;
    logic      can_close;  // idle and tRAS done
    logic      row_open;
    row_t      open_row;

    logic      rsp_valid;
    addr_t     rsp_addr;
    line_t     rsp_data;

    modport sched (
        output issue,
        output req,
        input  idle,
        input  can_close,
        input  row_open,
        input  open_row
    );

    modport bank (
        input  issue,
        input  req,
        output idle,
        output can_close,
        output row_open,
        output open_row,
        output rsp_valid,
        output rsp_addr,
        output rsp_data
    );

    modport resp (
        input rsp_valid,
        input rsp_addr,
        input rsp_data
    );

endinterface

`default_nettype wire

//--- hdl/frfcfs_scheduler.sv
// fr-fcfs scheduler with write beat assembly, age-ordered request queue, per-bank pick and tRRD
`timescale 1ns/1ps
`default_nettype none

module frfcfs_scheduler #(
    parameter int queue_size = 8,
    parameter int t_rrd      = 2
) (
    input  logic            itf,
    input  logic            rst,
    input  logic            read,
    input  logic            write,
    input  dram_pkg::addr_t addr,
    input  dram_pkg::beat_t wdata,
    output logic            ready,
    bank_if.sched           banks [dram_pkg::num_banks]
);
    import dram_pkg::*;

    localparam int idx_w  = $clog2(queue_size);
    localparam int cnt_w  = $clog2(queue_size + 1);
    localparam int beat_w = $clog2(burst_len);
    localparam int rrd_w  = $clog2(t_rrd + 2);

    dram_req_t          q      [queue_size];
    dram_req_t          q_next [queue_size];
    logic [cnt_w-1:0]   count;
    logic [cnt_w-1:0]   count_next;

    logic [beat_w-1:0]  beat_cnt;
    line_t              wr_line;
    logic               wr_beat;
    logic               rd_take;
    logic               push;
    dram_req_t          push_req;

    logic [rrd_w-1:0]   rrd_cnt;

    logic [num_banks-1:0] idle_v;
    logic [num_banks-1:0] can_close_v;
    logic [num_banks-1:0] row_open_v;
    row_t                 open_row_v [num_banks];

    logic [num_banks-1:0] pick_valid;
    logic [num_banks-1:0] pick_hit;
    logic [idx_w-1:0]     pick_idx [num_banks];
    logic [num_banks-1:0] issue_v;
    logic                 act_valid;
    logic [ba_width-1:0]  act_bank;
    logic [queue_size-1:0] deq;

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        assign idle_v[b]      = banks[b].idle;
        assign can_close_v[b] = banks[b].can_close;
        assign row_open_v[b]  = banks[b].row_open;
        assign open_row_v[b]  = banks[b].open_row;
        assign banks[b].issue = issue_v[b];
        assign banks[b].req   = q[pick_idx[b]];
    end

    assign ready   = (count != cnt_w'(queue_size));
    assign rd_take = read && ready;
    assign wr_beat = write && (beat_cnt != '0 || ready);   // ready only matters on beat 0
    assign push    = rd_take || (wr_beat && beat_cnt == beat_w'(burst_len - 1));

    always_comb begin
        push_req.read  = rd_take;
        push_req.addr  = addr;
        push_req.wdata = rd_take ? '0 : {wdata, wr_line[line_width-bus_width-1:0]};
    end

    // per bank pick the oldest row hit or else the oldest request
    always_comb begin
        pick_valid = '0;
        pick_hit   = '0;
        for (int b = 0; b < num_banks; b++) begin
            pick_idx[b] = '0;
            for (int i = 0; i < queue_size; i++) begin
                if (idle_v[b] && i < int'(count) && get_bank(q[i].addr) == ba_width'(b)) begin
                    if (!pick_hit[b] && row_open_v[b] && get_row(q[i].addr) == open_row_v[b]) begin
                        pick_idx[b]   = idx_w'(i);
                        pick_hit[b]   = 1'b1;
                        pick_valid[b] = 1'b1;
                    end else if (!pick_valid[b]) begin
                        pick_idx[b]   = idx_w'(i);
                        pick_valid[b] = 1'b1;
                    end
                end
            end
        end
    end

    // one activation at a time and the oldest pick wins
    always_comb begin
        act_valid = 1'b0;
        act_bank  = '0;
        for (int b = 0; b < num_banks; b++) begin
            if (pick_valid[b] && !pick_hit[b] && can_close_v[b] && rrd_cnt == '0) begin
                if (!act_valid || pick_idx[b] < pick_idx[act_bank]) begin
                    act_valid = 1'b1;
                    act_bank  = ba_width'(b);
                end
            end
        end
        for (int b = 0; b < num_banks; b++) begin
            issue_v[b] = pick_valid[b] && (pick_hit[b] || (act_valid && act_bank == ba_width'(b)));
        end
    end

    always_comb begin
        deq = '0;
        for (int i = 0; i < queue_size; i++) begin
            for (int b = 0; b < num_banks; b++) begin
                if (issue_v[b] && pick_idx[b] == idx_w'(i)) begin
                    deq[i] = 1'b1;
                end
            end
        end
    end

    // survivors move to the front and a new request goes behind them
    always_comb begin
        int j;
        j = 0;
        q_next = q;
        for (int i = 0; i < queue_size; i++) begin
            if (i < int'(count) && !deq[i]) begin
                q_next[j] = q[i];
                j++;
            end
        end
        if (push && j < queue_size) begin
            q_next[j] = push_req;
            j++;
        end
        count_next = cnt_w'(j);
    end

    always_ff @(posedge itf) begin
        if (rst) begin
            count    <= '0;
            beat_cnt <= '0;
            rrd_cnt  <= '0;
        end else begin
            count <= count_next;
            if (wr_beat) begin
                beat_cnt <= beat_cnt + 1'b1;   // wraps after the last beat
            end
            if (act_valid) begin
                rrd_cnt <= rrd_w'(t_rrd);
            end else if (rrd_cnt != '0) begin
                rrd_cnt <= rrd_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge itf) begin
        q <= q_next;
        if (wr_beat) begin
            wr_line[beat_cnt*bus_width +: bus_width] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bank_machine.sv
// bank machine with PRE/ACT/COL timing, open row tracking and line storage for one bank
`timescale 1ns/1ps
`default_nettype none

module bank_machine #(
    parameter int bank_index = 0,
    parameter int t_rp       = 3,
    parameter int t_rcd      = 3,
    parameter int t_ras      = 7,
    parameter int t_cl       = 3,
    parameter int t_wr       = 3
) (
    input  logic itf,
    input  logic rst,
    bank_if.bank bus
);
    import dram_pkg::*;

    localparam int t_a   = (t_rp > t_rcd) ? t_rp : t_rcd;
    localparam int t_b   = (t_ras > t_cl) ? t_ras : t_cl;
    localparam int t_c   = (t_a > t_b) ? t_a : t_b;
    localparam int t_max = (t_c > t_wr) ? t_c : t_wr;
    localparam int cnt_w = $clog2(t_max + 1);
    localparam int mem_w = ra_width + ca_width;

    bank_state_e      state;
    logic [cnt_w-1:0] rp_cnt;
    logic [cnt_w-1:0] rcd_cnt;
    logic [cnt_w-1:0] ras_cnt;
    logic [cnt_w-1:0] col_cnt;
    logic             row_open;
    row_t             open_row;

    dram_req_t        cur;         // request in service
    line_t            rd_line;
    line_t            mem [2**mem_w];

    logic             accept;
    logic             hit;
    logic             enter_col;
    logic             leave_col;
    dram_req_t        col_req;
    logic [mem_w-1:0] mem_idx;

    assign accept    = bus.issue && state == bank_idle
                       && get_bank(bus.req.addr) == ba_width'(bank_index);
    assign hit       = row_open && get_row(bus.req.addr) == open_row;
    assign enter_col = (accept && hit) || (state == bank_act && rcd_cnt == '0);
    assign leave_col = state == bank_col && col_cnt == '0;
    assign col_req   = (state == bank_idle) ? bus.req : cur;
    assign mem_idx   = {get_row(col_req.addr), get_col(col_req.addr)};

    assign bus.idle      = (state == bank_idle);
    assign bus.can_close = (state == bank_idle) && ras_cnt == '0;
    assign bus.row_open  = row_open;
    assign bus.open_row  = open_row;
    assign bus.rsp_valid = leave_col && cur.read;
    assign bus.rsp_addr  = cur.addr;
    assign bus.rsp_data  = rd_line;

    always_ff @(posedge itf) begin
        if (rst) begin
            state    <= bank_idle;
            rp_cnt   <= '0;
            rcd_cnt  <= '0;
            ras_cnt  <= '0;
            col_cnt  <= '0;
            row_open <= 1'b0;   // first access always precharges
            open_row <= '0;
        end else begin
            if (ras_cnt != '0) begin
                ras_cnt <= ras_cnt - 1'b1;
            end
            case (state)
                bank_idle: begin
                    if (accept && hit) begin
                        state <= bank_col;
                    end else if (accept) begin
                        state    <= bank_pre;
                        rp_cnt   <= cnt_w'(t_rp - 1);
                        row_open <= 1'b0;
                    end
                end
                bank_pre: begin
                    if (rp_cnt == '0) begin
                        state    <= bank_act;
                        rcd_cnt  <= cnt_w'(t_rcd - 1);
                        ras_cnt  <= cnt_w'(t_ras - 1);
                        row_open <= 1'b1;
                        open_row <= get_row(cur.addr);
                    end else begin
                        rp_cnt <= rp_cnt - 1'b1;
                    end
                end
                bank_act: begin
                    if (rcd_cnt == '0) begin
                        state <= bank_col;
                    end else begin
                        rcd_cnt <= rcd_cnt - 1'b1;
                    end
                end
                bank_col: begin
                    if (leave_col) begin
                        state <= bank_idle;
                    end else begin
                        col_cnt <= col_cnt - 1'b1;
                    end
                end
                default: state <= bank_idle;
            endcase
            if (enter_col) begin
                col_cnt <= col_req.read ? cnt_w'(t_cl - 1) : cnt_w'(t_wr - 1);
            end
        end
    end

    // storage is touched once, as the column phase starts
    always_ff @(posedge itf) begin
        if (accept) begin
            cur <= bus.req;
        end
        if (enter_col) begin
            if (col_req.read) begin
                rd_line <= mem[mem_idx];
            end else begin
                mem[mem_idx] <= col_req.wdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/response_queue.sv
// response queue that gathers finished reads in bank order and returns them as 4-beat bursts
`timescale 1ns/1ps
`default_nettype none

module response_queue #(
    parameter int queue_size = 8
) (
    input  logic            itf,
    input  logic            rst,
    bank_if.resp            banks [dram_pkg::num_banks],
    output logic            rvalid,
    output dram_pkg::addr_t raddr,
    output dram_pkg::beat_t rdata
);
    import dram_pkg::*;

    localparam int depth  = queue_size + num_banks;
    localparam int cnt_w  = $clog2(depth + 1);
    localparam int beat_w = $clog2(burst_len);

    typedef struct packed {
        addr_t addr;
        line_t data;
    } rsp_t;

    rsp_t               q      [depth];
    rsp_t               q_next [depth];
    logic [cnt_w-1:0]   count;
    logic [cnt_w-1:0]   count_next;
    logic [beat_w-1:0]  beat_cnt;
    logic               pop;

    logic [num_banks-1:0] rsp_valid_v;
    rsp_t                 rsp_v [num_banks];

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        assign rsp_valid_v[b] = banks[b].rsp_valid;
        assign rsp_v[b]       = '{addr: banks[b].rsp_addr, data: banks[b].rsp_data};
    end

    assign rvalid = (count != '0);
    assign raddr  = q[0].addr;
    assign rdata  = q[0].data[beat_cnt*bus_width +: bus_width];
    assign pop    = rvalid && beat_cnt == beat_w'(burst_len - 1);

    always_comb begin
        int j;
        j = 0;
        q_next = q;
        for (int i = 0; i < depth; i++) begin
            if (i < int'(count) && !(pop && i == 0)) begin
                q_next[j] = q[i];
                j++;
            end
        end
        for (int b = 0; b < num_banks; b++) begin
            if (rsp_valid_v[b] && j < depth) begin   // same-cycle completions go in lowest bank first
                q_next[j] = rsp_v[b];
                j++;
            end
        end
        count_next = cnt_w'(j);
    end

    always_ff @(posedge itf) begin
        if (rst) begin
            count    <= '0;
            beat_cnt <= '0;
        end else begin
            count <= count_next;
            if (rvalid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge itf) begin
        q <= q_next;
    end

endmodule

`default_nettype wire

//--- hdl/dram_model_top.sv
// dram model top level for a banked open-page dram with fr-fcfs scheduling and plain request ports
`timescale 1ns/1ps
`default_nettype none

module dram_model_top #(
    parameter int queue_size = 8,
    parameter int t_rp       = 3,
    parameter int t_rcd      = 3,
    parameter int t_ras      = 7,
    parameter int t_cl       = 3,
    parameter int t_wr       = 3,
    parameter int t_rrd      = 2
) (
    input  logic            itf,
    input  logic            rst,
    input  logic            read,
    input  logic            write,
    input  dram_pkg::addr_t addr,
    input  dram_pkg::beat_t wdata,
    output logic            ready,
    output logic            rvalid,
    output dram_pkg::addr_t raddr,
    output dram_pkg::beat_t rdata
);
    import dram_pkg::*;

    bank_if bank_bus [num_banks] ();

    frfcfs_scheduler #(
        .queue_size (queue_size),
        .t_rrd      (t_rrd)
    ) u_sched (
        .itf   (itf),
        .rst   (rst),
        .read  (read),
        .write (write),
        .addr  (addr),
        .wdata (wdata),
        .ready (ready),
        .banks (bank_bus)
    );

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        bank_machine #(
            .bank_index (b),
            .t_rp       (t_rp),
            .t_rcd      (t_rcd),
            .t_ras      (t_ras),
            .t_cl       (t_cl),
            .t_wr       (t_wr)
        ) u_bank (
            .itf (itf),
            .rst (rst),
            .bus (bank_bus[b])
        );
    end

    response_queue #(
        .queue_size (queue_size)
    ) u_resp (
        .itf    (itf),
        .rst    (rst),
        .banks  (bank_bus),
        .rvalid (rvalid),
        .raddr  (raddr),
        .rdata  (rdata)
    );

endmodule

`default_nettype wire

//--- sim/dram_model_assert.sv
// dram model port assertions for request exclusivity, four-beat returns and quiet reset
`timescale 1ns/1ps
`default_nettype none

module dram_model_assert (
    input wire logic            itf,
    input wire logic            rst,
    input wire logic            read,
    input wire logic            write,
    input wire logic            rvalid,
    input wire dram_pkg::addr_t raddr
);
    import dram_pkg::*;

    localparam int beat_w = $clog2(burst_len);

    logic [beat_w-1:0] beat_cnt;
    logic              rst_d = 1'b0;   // keeps the reset check off the first, unsettled edge
    int                fail_count = 0;

    always_ff @(posedge itf) begin
        rst_d <= rst;
        if (rst) begin
            beat_cnt <= '0;
        end else if (rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    a_no_read_write: assert property (@(posedge itf) disable iff (rst) !(read && write))
        else begin
            $error("read and write high together");
            fail_count++;
        end

    a_burst_whole: assert property (@(posedge itf) disable iff (rst) !rvalid |-> beat_cnt == '0)
        else begin
            $error("rvalid run ended inside a burst");
            fail_count++;
        end

    a_raddr_stable: assert property (@(posedge itf) disable iff (rst)
        (rvalid && beat_cnt != '0) |-> $stable(raddr))
        else begin
            $error("raddr changed inside a burst");
            fail_count++;
        end

    a_quiet_reset: assert property (@(posedge itf) (rst && rst_d) |-> !rvalid)
        else begin
            $error("rvalid high during reset");
            fail_count++;
        end

endmodule

bind dram_model_top dram_model_assert u_assert (
    .itf    (itf),
    .rst    (rst),
    .read   (read),
    .write  (write),
    .rvalid (rvalid),
    .raddr  (raddr)
);

`default_nettype wire

//--- sim/dram_model_tb.sv
// dram model testbench with table-driven bursts checked against a reference memory and return order
`timescale 1ns/1ps
`default_nettype none

module dram_model_tb;
    import dram_pkg::*;

    localparam int t_rp        = 3;
    localparam int t_rcd       = 3;
    localparam int t_cl        = 3;
    localparam int max_entries = 64;
    localparam int num_lines   = 2 ** (addr_width - offset_width);

    localparam logic [1:0] k_idle  = 2'd0;   // check ready/rvalid quiet for a while
    localparam logic [1:0] k_write = 2'd1;
    localparam logic [1:0] k_read  = 2'd2;
    localparam logic [1:0] k_drain = 2'd3;   // wait for all returns, then close the test

    logic  itf;
    logic  rst;
    logic  read;
    logic  write;
    addr_t addr;
    beat_t wdata;
    logic  ready;
    logic  rvalid;
    addr_t raddr;
    beat_t rdata;

    // tbl_exp holds a read's return order tag or a drain's back-pressure flag
    logic [1:0] tbl_kind [max_entries];
    int         tbl_test [max_entries];
    addr_t      tbl_addr [max_entries];
    int         tbl_exp  [max_entries];
    int         n_entries;

    line_t ref_mem [num_lines];
    int    pending [num_lines];
    int    ord_tag [num_lines];
    int    outstanding;
    int    ord_next;
    bit    bp_seen;
    int    cur_test;
    int    err_count;
    int    test_err;
    int    tests_run;
    int    tests_failed;
    int    cycles;
    int    limit;
    int    beat;
    addr_t ret_addr;
    line_t ret_line;

    dram_model_top dut0 (
        .itf    (itf),
        .rst    (rst),
        .read   (read),
        .write  (write),
        .addr   (addr),
        .wdata  (wdata),
        .ready  (ready),
        .rvalid (rvalid),
        .raddr  (raddr),
        .rdata  (rdata)
    );

    initial begin
        itf = 1'b0;
        forever #4 itf = ~itf;
    end

    // fields from the low end are offset, column, bank and row
    function automatic addr_t line_addr(input int row, input int bank, input int col);
        return {row[2:0], bank[1:0], col[1:0], 3'b000};
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1:       return "idle after reset";
            2:       return "write then read one line";
            3:       return "all banks, several rows";
            4:       return "row hit priority";
            default: return "back-pressure";
        endcase
    endfunction

    task automatic add_entry(input logic [1:0] kind, input int test, input addr_t a,
                             input int exp);
        tbl_kind[n_entries] = kind;
        tbl_test[n_entries] = test;
        tbl_addr[n_entries] = a;
        tbl_exp[n_entries]  = exp;
        n_entries++;
    endtask

    task automatic build_table();
        add_entry(k_idle, 1, '0, 0);
        add_entry(k_drain, 1, '0, 0);
        add_entry(k_write, 2, line_addr(3, 0, 1), 0);
        add_entry(k_read, 2, line_addr(3, 0, 1), 0);
        add_entry(k_drain, 2, '0, 0);
        for (int b = 0; b < num_banks; b++) begin
            add_entry(k_write, 3, line_addr(b, b, 0), 0);
            add_entry(k_write, 3, line_addr((b + 5) % 8, b, 3), 0);
        end
        for (int b = num_banks - 1; b >= 0; b--) begin
            add_entry(k_read, 3, line_addr((b + 5) % 8, b, 3), 0);
            add_entry(k_read, 3, line_addr(b, b, 0), 0);
        end
        add_entry(k_drain, 3, '0, 0);
        add_entry(k_write, 4, line_addr(1, 2, 1), 0);   // keeps bank 2 busy for t_wr
        add_entry(k_read, 4, line_addr(2, 2, 0), 2);
        add_entry(k_read, 4, line_addr(1, 2, 1), 1);    // hits the open row and comes first
        add_entry(k_drain, 4, '0, 0);
        for (int i = 0; i < queue_depth_reads(); i++) begin
            add_entry(k_read, 5, (i % 2 != 0) ? line_addr(6, 1, 3) : line_addr(1, 1, 0), 0);
        end
        add_entry(k_drain, 5, '0, 1);
    endtask

    function automatic int queue_depth_reads();
        return 12;   // more than the 8-entry request queue
    endfunction

    task automatic count_error();
        err_count++;
        test_err++;
    endtask

    task automatic wait_ready();
        while (!ready) begin
            @(posedge itf);
            #1;
        end
    endtask

    task automatic send_write(input addr_t a);
        line_t line;
        for (int b = 0; b < burst_len; b++) begin
            line[b*bus_width +: bus_width] = beat_t'($urandom);
        end
        wait_ready();   // sampled on the first beat only
        for (int b = 0; b < burst_len; b++) begin
            write = 1'b1;
            addr  = a;
            wdata = line[b*bus_width +: bus_width];
            @(posedge itf);
            #1;
        end
        write = 1'b0;
        ref_mem[a[addr_width-1:offset_width]] = line;
    endtask

    task automatic send_read(input addr_t a, input int tag);
        wait_ready();
        read = 1'b1;
        addr = a;
        pending[a[addr_width-1:offset_width]]++;
        outstanding++;
        if (tag > 0) begin
            ord_tag[a[addr_width-1:offset_width]] = tag;
        end
        @(posedge itf);
        #1;
        read = 1'b0;
    endtask

    task automatic check_idle();
        repeat (10) begin
            if (ready !== 1'b1) begin
                $display("ERR ready: got %h expected %h", ready, 1'b1);
                count_error();
            end
            if (rvalid !== 1'b0) begin
                $display("ERR rvalid: got %h expected %h", rvalid, 1'b0);
                count_error();
            end
            @(posedge itf);
            #1;
        end
    endtask

    task automatic finish_test(input int test, input int exp_bp);
        while (outstanding != 0) begin
            @(posedge itf);
            #1;
        end
        if (exp_bp != 0 && !bp_seen) begin
            $display("test %0d: ready never fell while the request queue was full", test);
            count_error();
        end
        if (ready !== 1'b1) begin
            $display("ERR ready: got %h expected %h", ready, 1'b1);
            count_error();
        end
        $display("test %0d (%s): %0d errors", test, test_name(test), test_err);
        tests_run++;
        if (test_err != 0) begin
            tests_failed++;
        end
        test_err = 0;
        bp_seen  = 1'b0;
        ord_next = 1;
    endtask

    task automatic check_return(input addr_t a, input line_t line);
        int idx;
        idx = int'(a[addr_width-1:offset_width]);
        if (pending[idx] == 0) begin
            $display("test %0d: read data returned for %h, which was never requested",
                     cur_test, a);
            count_error();
        end else begin
            pending[idx]--;
            outstanding--;
            if (line !== ref_mem[idx]) begin
                $display("ERR rdata at raddr %h: got %h expected %h", a, line, ref_mem[idx]);
                count_error();
            end
            if (ord_tag[idx] != 0) begin
                if (ord_tag[idx] != ord_next) begin
                    $display("test %0d: read to %h returned out of order", cur_test, a);
                    count_error();
                end
                ord_next++;
                ord_tag[idx] = 0;
            end
        end
    endtask

    // scoreboard gathers four beats per line
    always @(posedge itf) begin
        if (!rst && rvalid) begin
            if (beat == 0) begin
                ret_addr = raddr;
            end
            ret_line[beat*bus_width +: bus_width] = rdata;
            if (beat == burst_len - 1) begin
                check_return(ret_addr, ret_line);
                beat = 0;
            end else begin
                beat++;
            end
        end
    end

    always @(posedge itf) begin
        if (!rst && !ready) begin
            bp_seen = 1'b1;
        end
    end

    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge itf);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(1137));
        rst   = 1'b1;
        read  = 1'b0;
        write = 1'b0;
        addr  = '0;
        wdata = '0;
        n_entries = 0;
        outstanding = 0;
        ord_next = 1;
        bp_seen = 1'b0;
        cur_test = 0;
        err_count = 0;
        test_err = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        beat = 0;
        for (int i = 0; i < num_lines; i++) begin
            pending[i] = 0;
            ord_tag[i] = 0;
        end
        build_table();
        limit = n_entries * (t_rp + t_rcd + t_cl + 8) + 200;
        repeat (4) @(posedge itf);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            cur_test = tbl_test[i];
            case (tbl_kind[i])
                k_idle:  check_idle();
                k_write: send_write(tbl_addr[i]);
                k_read:  send_read(tbl_addr[i], tbl_exp[i]);
                default: finish_test(tbl_test[i], tbl_exp[i]);
            endcase
        end
        if (dut0.u_assert.fail_count != 0) begin
            $display("%0d port assertion failures during the run", dut0.u_assert.fail_count);
            err_count += dut0.u_assert.fail_count;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dram_model_top.f
hdl/dram_pkg.sv
hdl/bank_if.sv
hdl/frfcfs_scheduler.sv
hdl/bank_machine.sv
hdl/response_queue.sv
hdl/dram_model_top.sv
sim/dram_model_assert.sv
sim/dram_model_tb.sv

//--- Bender.yml
package:
  name: dram_model

sources:
  - hdl/dram_pkg.sv
  - hdl/bank_if.sv
  - hdl/frfcfs_scheduler.sv
  - hdl/bank_machine.sv
  - hdl/response_queue.sv
  - hdl/dram_model_top.sv
  - target: simulation
    files:
      - sim/dram_model_assert.sv
      - sim/dram_model_tb.sv
